// ==== logic/corr_pkg.sv ====
`default_nettype none

package corr_pkg;

   // ------------------------------
   // Antenna side
   // ------------------------------
   localparam int NUM_ANT  = 8;
   localparam int ANT_BITS = $clog2(NUM_ANT);

   // Pairs per block, also the cycles per sample
   localparam int TRATE      = 4;
   localparam int NUM_BLOCKS = 2;
   localparam int SLOT_BITS  = 2;

   // ------------------------------
   // Accumulation
   // ------------------------------
   localparam int ACCUM_BITS    = 8;
   localparam int INTEG_SAMPLES = 200;
   localparam int SAMPLE_BITS   = $clog2(INTEG_SAMPLES);
   // Slot enable to valid result
   localparam int PIPE_LATENCY  = 3;

   // Entry is {antenna a, antenna b}, indexed by block * TRATE + slot
   localparam logic [2*ANT_BITS-1:0] PAIR_TABLE [0:NUM_BLOCKS*TRATE-1] = '{
      {3'd0, 3'd1}, {3'd0, 3'd2}, {3'd0, 3'd3}, {3'd1, 3'd2},
      {3'd1, 3'd3}, {3'd2, 3'd3}, {3'd4, 3'd5}, {3'd6, 3'd7}
   };

   // ------------------------------
   // Bus address map
   // ------------------------------
   // Word = block * 8 + slot * 2 + (0 cos, 1 sin)
   localparam int VIS_WORDS     = 16;
   localparam int VIS_ADDR_BITS = $clog2(VIS_WORDS);
   localparam int STATUS_ADDR   = 16;
   localparam int WB_ADDR_BITS  = 5;
   localparam int WB_DATA_BITS  = 16;

   // Sequencer states
   typedef enum logic {
      SEQ_IDLE,
      SEQ_RUN
   } seq_state_t;

endpackage

`default_nettype wire

// ==== logic/corr_sequencer.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_sequencer import corr_pkg::*; (
   input  logic                 clk_x,
   input  logic                 reset,
   input  logic                 sample_valid,
   input  logic [NUM_ANT-1:0]   ant_re,
   input  logic [NUM_ANT-1:0]   ant_im,
   output logic                 slot_en,
   output logic [SLOT_BITS-1:0] slot,
   output logic                 first,
   output logic                 last,
   output logic [NUM_ANT-1:0]   cap_re,
   output logic [NUM_ANT-1:0]   cap_im
);

   seq_state_t             state;
   logic [SAMPLE_BITS-1:0] sample_cnt;
   logic                   sweep_end;
   logic                   start;

   // Final slot of the current sweep
   assign sweep_end = (state == SEQ_RUN) && (slot == SLOT_BITS'(TRATE - 1));
   // New sweep when idle, or back to back right after the final slot
   assign start = sample_valid && ((state == SEQ_IDLE) || sweep_end);

   // ------------------------------
   // Slot sweep FSM and frame count
   // ------------------------------
   always_ff @(posedge clk_x) begin
      if (reset) begin
         state      <= SEQ_IDLE;
         slot_en    <= 1'b0;
         slot       <= '0;
         first      <= 1'b0;
         last       <= 1'b0;
         sample_cnt <= '0;
      end else if (start) begin
         state   <= SEQ_RUN;
         slot_en <= 1'b1;
         slot    <= '0;
         // Flags hold for the whole sweep
         first   <= (sample_cnt == '0);
         last    <= (sample_cnt == SAMPLE_BITS'(INTEG_SAMPLES - 1));
         // Wrap at the frame length
         if (sample_cnt == SAMPLE_BITS'(INTEG_SAMPLES - 1)) begin
            sample_cnt <= '0;
         end else begin
            sample_cnt <= sample_cnt + 1'b1;
         end
      end else begin
         case (state)
            SEQ_RUN: begin
               if (sweep_end) begin
                  state   <= SEQ_IDLE;
                  slot_en <= 1'b0;
               end else begin
                  slot <= slot + 1'b1;
               end
            end
            default: begin
               slot_en <= 1'b0;
            end
         endcase
      end
   end

   // Sample bits stay put until the next accepted sample
   always_ff @(posedge clk_x) begin
      if (start) begin
         cap_re <= ant_re;
         cap_im <= ant_im;
      end
   end

endmodule

`default_nettype wire

// ==== logic/cos_sin_accum.sv ====
`timescale 1ns/1ps
`default_nettype none

module cos_sin_accum import corr_pkg::*; (
   input  logic                  clk_x,
   input  logic                  reset,
   input  logic                  en,
   input  logic                  clear,
   input  logic                  a_re,
   input  logic                  b_re,
   input  logic                  b_im,
   input  logic [ACCUM_BITS-1:0] acc_cos,
   input  logic [ACCUM_BITS-1:0] acc_sin,
   output logic                  vld,
   output logic [ACCUM_BITS-1:0] q_cos,
   output logic [ACCUM_BITS-1:0] q_sin
);

   logic                  agree_cos;
   logic                  agree_sin;
   logic [ACCUM_BITS-1:0] base_cos;
   logic [ACCUM_BITS-1:0] base_sin;

   // ------------------------------
   // One-bit products
   // ------------------------------
   // Agreement of signs, cos term
   assign agree_cos = a_re ~^ b_re;
   // Quadrature term against imaginary of b
   assign agree_sin = a_re ~^ b_im;

   // First sample of a frame starts from zero
   assign base_cos = clear ? '0 : acc_cos;
   assign base_sin = clear ? '0 : acc_sin;

   // Valid doubles as memory write enable
   always_ff @(posedge clk_x) begin
      if (reset) begin
         vld <= 1'b0;
      end else begin
         vld <= en;
      end
   end

   // Adder stage
   always_ff @(posedge clk_x) begin
      if (en) begin
         q_cos <= base_cos + ACCUM_BITS'(agree_cos);
         q_sin <= base_sin + ACCUM_BITS'(agree_sin);
      end
   end

endmodule

`default_nettype wire

// ==== logic/corr_block.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_block import corr_pkg::*; #(
   parameter int BLOCK_ID = 0
) (
   input  logic                  clk_x,
   input  logic                  reset,
   input  logic                  slot_en,
   input  logic [SLOT_BITS-1:0]  slot,
   input  logic                  first,
   input  logic                  last,
   input  logic [NUM_ANT-1:0]    cap_re,
   input  logic [NUM_ANT-1:0]    cap_im,
   output logic                  res_vld,
   output logic [SLOT_BITS-1:0]  res_slot,
   output logic                  res_last,
   output logic [ACCUM_BITS-1:0] res_cos,
   output logic [ACCUM_BITS-1:0] res_sin
);

   // Accumulators, one entry per slot
   logic [ACCUM_BITS-1:0] cos_mem [0:TRATE-1];
   logic [ACCUM_BITS-1:0] sin_mem [0:TRATE-1];

   logic [2*ANT_BITS-1:0] pair;
   logic [ANT_BITS-1:0]   ant_a;
   logic [ANT_BITS-1:0]   ant_b;

   // Stage 1 and 2 registers
   logic                  en1, en2;
   logic                  first1, first2;
   logic                  last1, last2;
   logic [SLOT_BITS-1:0]  slot1, slot2;
   logic                  a_re1, b_re1, b_im1;
   logic                  a_re2, b_re2, b_im2;
   logic [ACCUM_BITS-1:0] cos1, sin1, cos2, sin2;

   // ------------------------------
   // Pair lookup for this block
   // ------------------------------
   assign pair  = PAIR_TABLE[BLOCK_ID*TRATE + int'(slot)];
   assign ant_a = pair[2*ANT_BITS-1:ANT_BITS];
   assign ant_b = pair[ANT_BITS-1:0];

   // Control side of the pipeline
   always_ff @(posedge clk_x) begin
      if (reset) begin
         {en1, en2, first1, first2, last1, last2} <= '0;
         res_last <= 1'b0;
      end else begin
         {en1, first1, last1} <= {slot_en, first, last};
         {en2, first2, last2} <= {en1, first1, last1};
         // Last flag lines up with the adder output
         if (en2) begin
            res_last <= last2;
         end
      end
   end

   // ------------------------------
   // Stage 1 read, stage 2 operands
   // ------------------------------
   always_ff @(posedge clk_x) begin
      slot1 <= slot;
      a_re1 <= cap_re[ant_a];
      b_re1 <= cap_re[ant_b];
      b_im1 <= cap_im[ant_b];
      cos1  <= cos_mem[slot];
      sin1  <= sin_mem[slot];
      {slot2, a_re2, b_re2, b_im2} <= {slot1, a_re1, b_re1, b_im1};
      {cos2, sin2} <= {cos1, sin1};
      // Write address travels with the adder stage
      if (en2) begin
         res_slot <= slot2;
      end
   end

   // Stage 3 adder
   cos_sin_accum u_accum (
      .clk_x   (clk_x),
      .reset   (reset),
      .en      (en2),
      .clear   (first2),
      .a_re    (a_re2),
      .b_re    (b_re2),
      .b_im    (b_im2),
      .acc_cos (cos2),
      .acc_sin (sin2),
      .vld     (res_vld),
      .q_cos   (res_cos),
      .q_sin   (res_sin)
   );

   // Write back lands before the slot is read again
   always_ff @(posedge clk_x) begin
      if (res_vld) begin
         cos_mem[res_slot] <= res_cos;
         sin_mem[res_slot] <= res_sin;
      end
   end

endmodule

`default_nettype wire

// ==== logic/vis_bank.sv ====
`timescale 1ns/1ps
`default_nettype none

module vis_bank import corr_pkg::*; (
   input  logic                    clk_x,
   input  logic                    reset,
   input  logic                    b0_res_vld,
   input  logic [SLOT_BITS-1:0]    b0_res_slot,
   input  logic                    b0_res_last,
   input  logic [ACCUM_BITS-1:0]   b0_res_cos,
   input  logic [ACCUM_BITS-1:0]   b0_res_sin,
   input  logic                    b1_res_vld,
   input  logic [SLOT_BITS-1:0]    b1_res_slot,
   input  logic                    b1_res_last,
   input  logic [ACCUM_BITS-1:0]   b1_res_cos,
   input  logic [ACCUM_BITS-1:0]   b1_res_sin,
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  logic [WB_ADDR_BITS-1:0] wb_adr,
   input  logic [WB_DATA_BITS-1:0] wb_dat_w,
   output logic [WB_DATA_BITS-1:0] wb_dat_r,
   output logic                    wb_ack
);

   // Two banks of visibility words
   logic [ACCUM_BITS-1:0]   vis_buf [0:1][0:VIS_WORDS-1];
   logic                    bank_sel;
   logic [WB_DATA_BITS-1:0] frame_cnt;
   logic                    frame_end;
   logic                    bus_req;

   // Results gathered per block
   logic                  wr_en   [NUM_BLOCKS];
   logic [SLOT_BITS-1:0]  wr_slot [NUM_BLOCKS];
   logic [ACCUM_BITS-1:0] wr_cos  [NUM_BLOCKS];
   logic [ACCUM_BITS-1:0] wr_sin  [NUM_BLOCKS];

   // Word address of a block's slot, term 0 cos or 1 sin
   function automatic logic [VIS_ADDR_BITS-1:0] word_index(
      input int blk, input logic [SLOT_BITS-1:0] s, input logic term);
      return VIS_ADDR_BITS'(blk * 2 * TRATE + 2 * int'(s) + int'(term));
   endfunction

   // Only the final sums of a frame are kept
   assign wr_en[0]   = b0_res_vld && b0_res_last;
   assign wr_en[1]   = b1_res_vld && b1_res_last;
   assign wr_slot[0] = b0_res_slot;
   assign wr_slot[1] = b1_res_slot;
   assign {wr_cos[0], wr_sin[0]} = {b0_res_cos, b0_res_sin};
   assign {wr_cos[1], wr_sin[1]} = {b1_res_cos, b1_res_sin};

   // Blocks run in lockstep, block 1 slot 3 closes the frame
   assign frame_end = wr_en[1] && (b1_res_slot == SLOT_BITS'(TRATE - 1));

   // ------------------------------
   // Active bank writes
   // ------------------------------
   always_ff @(posedge clk_x) begin
      for (int b = 0; b < NUM_BLOCKS; b++) begin
         if (wr_en[b]) begin
            vis_buf[bank_sel][word_index(b, wr_slot[b], 1'b0)] <= wr_cos[b];
            vis_buf[bank_sel][word_index(b, wr_slot[b], 1'b1)] <= wr_sin[b];
         end
      end
   end

   // Flip and count together with the last write
   always_ff @(posedge clk_x) begin
      if (reset) begin
         bank_sel  <= 1'b0;
         frame_cnt <= '0;
      end else if (frame_end) begin
         bank_sel  <= ~bank_sel;
         frame_cnt <= frame_cnt + 1'b1;
      end
   end

   // ------------------------------
   // Wishbone classic slave
   // ------------------------------
   // One ack per request, write data is discarded
   assign bus_req = wb_cyc && wb_stb && !wb_ack;

   always_ff @(posedge clk_x) begin
      if (reset) begin
         wb_ack <= 1'b0;
      end else begin
         wb_ack <= bus_req;
      end
   end

   // Reads come from the completed bank
   always_ff @(posedge clk_x) begin
      if (bus_req) begin
         if (wb_we) begin
            wb_dat_r <= '0;
         end else if (wb_adr < WB_ADDR_BITS'(VIS_WORDS)) begin
            wb_dat_r <= WB_DATA_BITS'(vis_buf[~bank_sel][wb_adr[VIS_ADDR_BITS-1:0]]);
         end else if (wb_adr == WB_ADDR_BITS'(STATUS_ADDR)) begin
            wb_dat_r <= frame_cnt;
         end else begin
            wb_dat_r <= '0;
         end
      end
   end

endmodule

`default_nettype wire

// ==== logic/corr_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_top import corr_pkg::*; (
   input  logic                    clk_x,
   input  logic                    reset,
   // Antenna side
   input  logic                    sample_valid,
   input  logic [NUM_ANT-1:0]      ant_re,
   input  logic [NUM_ANT-1:0]      ant_im,
   // Wishbone
   input  logic                    wb_cyc,
   input  logic                    wb_stb,
   input  logic                    wb_we,
   input  logic [WB_ADDR_BITS-1:0] wb_adr,
   input  logic [WB_DATA_BITS-1:0] wb_dat_w,
   output logic [WB_DATA_BITS-1:0] wb_dat_r,
   output logic                    wb_ack
);

   // ------------------------------
   // Sequencer broadcast
   // ------------------------------
   logic                  slot_en;
   logic [SLOT_BITS-1:0]  slot;
   logic                  first;
   logic                  last;
   logic [NUM_ANT-1:0]    cap_re;
   logic [NUM_ANT-1:0]    cap_im;

   // Block results
   logic                  b0_vld, b1_vld;
   logic [SLOT_BITS-1:0]  b0_slot, b1_slot;
   logic                  b0_last, b1_last;
   logic [ACCUM_BITS-1:0] b0_cos, b1_cos;
   logic [ACCUM_BITS-1:0] b0_sin, b1_sin;

   corr_sequencer u_seq (
      .clk_x, .reset, .sample_valid, .ant_re, .ant_im,
      .slot_en, .slot, .first, .last, .cap_re, .cap_im
   );

   // Pairs 0 to 3
   corr_block #(.BLOCK_ID(0)) u_block0 (
      .clk_x, .reset, .slot_en, .slot, .first, .last, .cap_re, .cap_im,
      .res_vld (b0_vld), .res_slot (b0_slot), .res_last (b0_last),
      .res_cos (b0_cos), .res_sin  (b0_sin)
   );

   // Pairs 4 to 7
   corr_block #(.BLOCK_ID(1)) u_block1 (
      .clk_x, .reset, .slot_en, .slot, .first, .last, .cap_re, .cap_im,
      .res_vld (b1_vld), .res_slot (b1_slot), .res_last (b1_last),
      .res_cos (b1_cos), .res_sin  (b1_sin)
   );

   // Double-buffered store and bus port
   vis_bank u_bank (
      .clk_x, .reset,
      .b0_res_vld (b0_vld), .b0_res_slot (b0_slot), .b0_res_last (b0_last),
      .b0_res_cos (b0_cos), .b0_res_sin  (b0_sin),
      .b1_res_vld (b1_vld), .b1_res_slot (b1_slot), .b1_res_last (b1_last),
      .b1_res_cos (b1_cos), .b1_res_sin  (b1_sin),
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
   );

endmodule

`default_nettype wire

// ==== verif/corr_assert.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_assert import corr_pkg::*; (
   input logic clk_x,
   input logic reset,
   input logic sample_valid,
   input logic slot_en,
   input logic b0_vld,
   input logic wb_cyc,
   input logic wb_stb,
   input logic wb_ack
);

   int fail_cnt = 0;

   // ------------------------------
   // Wishbone handshake
   // ------------------------------
   // New request gets its ack one cycle later
   ack_after_req: assert property (@(posedge clk_x) disable iff (reset)
      (wb_cyc && wb_stb && !wb_ack) |=> wb_ack)
      else begin
         $error("wb_ack missing one cycle after a request");
         fail_cnt++;
      end

   // Ack never rises without a request
   ack_needs_req: assert property (@(posedge clk_x) disable iff (reset)
      $rose(wb_ack) |-> $past(wb_cyc && wb_stb))
      else begin
         $error("wb_ack rose without a request");
         fail_cnt++;
      end

   // Single-cycle ack
   ack_one_cycle: assert property (@(posedge clk_x) disable iff (reset)
      wb_ack |=> !wb_ack)
      else begin
         $error("wb_ack held longer than one cycle");
         fail_cnt++;
      end

   ack_in_reset: assert property (@(posedge clk_x) reset |=> !wb_ack)
      else begin
         $error("wb_ack high during reset");
         fail_cnt++;
      end

   // ------------------------------
   // Antenna side and pipeline
   // ------------------------------
   sample_gap: assert property (@(posedge clk_x) disable iff (reset)
      sample_valid |=> !sample_valid [*TRATE-1])
      else begin
         $error("sample_valid pulses closer than TRATE cycles");
         fail_cnt++;
      end

   // Block 0 result follows each slot strobe
   pipe_latency: assert property (@(posedge clk_x) disable iff (reset)
      slot_en |-> ##PIPE_LATENCY b0_vld)
      else begin
         $error("res_vld late or missing after slot_en");
         fail_cnt++;
      end

endmodule

bind corr_top corr_assert u_assert (
   .clk_x        (clk_x),
   .reset        (reset),
   .sample_valid (sample_valid),
   .slot_en      (slot_en),
   .b0_vld       (b0_vld),
   .wb_cyc       (wb_cyc),
   .wb_stb       (wb_stb),
   .wb_ack       (wb_ack)
);

`default_nettype wire

// ==== verif/corr_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module corr_tb import corr_pkg::*; ();

   localparam int CLK_PERIOD      = 8;
   localparam int SAMPLE_GAP      = 5;
   localparam int BUS_TIMEOUT     = 20;
   localparam int WATCHDOG_CYCLES = 3 * INTEG_SAMPLES * SAMPLE_GAP + 2000;

   logic                    clk_x;
   logic                    reset;
   logic                    sample_valid;
   logic [NUM_ANT-1:0]      ant_re;
   logic [NUM_ANT-1:0]      ant_im;
   logic                    wb_cyc;
   logic                    wb_stb;
   logic                    wb_we;
   logic [WB_ADDR_BITS-1:0] wb_adr;
   logic [WB_DATA_BITS-1:0] wb_dat_w;
   logic [WB_DATA_BITS-1:0] wb_dat_r;
   logic                    wb_ack;

   logic [31:0] lfsr;
   // Expected visibility words by 2 * pair + term
   int          exp_word  [0:VIS_WORDS-1];
   // Snapshot of the last completed frame
   int          held_word [0:VIS_WORDS-1];

   corr_top u_dut (
      .clk_x, .reset, .sample_valid, .ant_re, .ant_im,
      .wb_cyc, .wb_stb, .wb_we, .wb_adr, .wb_dat_w, .wb_dat_r, .wb_ack
   );

   initial begin
      clk_x = 1'b0;
      forever #(CLK_PERIOD / 2) clk_x = ~clk_x;
   end

   // ------------------------------
   // Stimulus helpers
   // ------------------------------
   // Drive point just after the rising edge
   task automatic tick();
      @(posedge clk_x);
      #1;
   endtask

   // Fibonacci LFSR with taps 32 22 2 1
   function automatic logic lfsr_bit();
      logic fb;
      fb   = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], fb};
      return fb;
   endfunction

   // Reference model counting agreements per pair and term
   function automatic void model_add(input logic [NUM_ANT-1:0] re,
                                     input logic [NUM_ANT-1:0] im);
      int a;
      int b;
      for (int p = 0; p < NUM_BLOCKS * TRATE; p++) begin
         a = int'(PAIR_TABLE[p][2*ANT_BITS-1:ANT_BITS]);
         b = int'(PAIR_TABLE[p][ANT_BITS-1:0]);
         exp_word[2*p]   += (re[a] == re[b]) ? 1 : 0;
         exp_word[2*p+1] += (re[a] == im[b]) ? 1 : 0;
      end
   endfunction

   task automatic check_equal(input string name, input int expected, input int actual);
      assert (actual == expected) else begin
         $display("error %s: expected %0d, actual %0d", name, expected, actual);
         $display("TEST FAILED");
         $fatal(1);
      end
   endtask

   // Single Wishbone classic cycle
   task automatic bus_cycle(input logic we, input int adr, input int wdata,
                            output int rdata);
      int waited;
      waited   = 0;
      wb_cyc   = 1'b1;
      wb_stb   = 1'b1;
      wb_we    = we;
      wb_adr   = WB_ADDR_BITS'(adr);
      wb_dat_w = WB_DATA_BITS'(wdata);
      do begin
         tick();
         waited++;
         if (waited > BUS_TIMEOUT) begin
            $display("Bus hang, no wb_ack within %0d cycles at address %0d",
                     BUS_TIMEOUT, adr);
            $display("TEST FAILED");
            $fatal(1);
         end
      end while (!wb_ack);
      rdata  = int'(wb_dat_r);
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      wb_we  = 1'b0;
   endtask

   // One frame of random samples spaced gap cycles apart
   task automatic send_frame(input int gap);
      logic [NUM_ANT-1:0] re;
      logic [NUM_ANT-1:0] im;
      for (int i = 0; i < VIS_WORDS; i++) begin
         exp_word[i] = 0;
      end
      for (int s = 0; s < INTEG_SAMPLES; s++) begin
         for (int a = 0; a < NUM_ANT; a++) begin
            re[a] = lfsr_bit();
            im[a] = lfsr_bit();
         end
         model_add(re, im);
         sample_valid = 1'b1;
         ant_re       = re;
         ant_im       = im;
         tick();
         sample_valid = 1'b0;
         repeat (gap - 1) tick();
      end
   endtask

   // Poll the status word until the frame count arrives
   task automatic wait_frame(input int count);
      int value;
      int polls;
      value = -1;
      polls = 0;
      while (value != count) begin
         bus_cycle(1'b0, STATUS_ADDR, 0, value);
         polls++;
         if (polls > 100) begin
            $display("Frame count stuck at %0d while waiting for %0d", value, count);
            $display("TEST FAILED");
            $fatal(1);
         end
      end
   endtask

   task automatic compare_bank(input string name, input int want [0:VIS_WORDS-1]);
      int value;
      for (int i = 0; i < VIS_WORDS; i++) begin
         bus_cycle(1'b0, i, 0, value);
         check_equal($sformatf("%s word %0d", name, i), want[i], value);
      end
   endtask

   // ------------------------------
   // Watchdogs
   // ------------------------------
   initial begin
      #(WATCHDOG_CYCLES * CLK_PERIOD);
      $display("Watchdog expired before the test sequence finished");
      $display("TEST FAILED");
      $fatal(1);
   end

   // Stop at the first bound assertion failure
   initial begin
      wait (u_dut.u_assert.fail_cnt != 0);
      $display("A bound assertion on the DUT failed");
      $display("TEST FAILED");
      $fatal(1);
   end

   // ------------------------------
   // Test sequence
   // ------------------------------
   initial begin
      int value;
      lfsr         = 32'haef;
      reset        = 1'b1;
      sample_valid = 1'b0;
      ant_re       = '0;
      ant_im       = '0;
      // Request held across reset must stay unacknowledged
      wb_cyc       = 1'b1;
      wb_stb       = 1'b1;
      wb_we        = 1'b0;
      wb_adr       = '0;
      wb_dat_w     = '0;
      repeat (5) @(posedge clk_x);
      #1;
      reset  = 1'b0;
      wb_cyc = 1'b0;
      wb_stb = 1'b0;
      tick();

      // Status after reset and a zero unmapped read
      bus_cycle(1'b0, STATUS_ADDR, 0, value);
      check_equal("reset_status", 0, value);
      bus_cycle(1'b0, STATUS_ADDR + 1, 0, value);
      check_equal("unmapped_read", 0, value);

      // Two frames at the relaxed spacing
      send_frame(SAMPLE_GAP);
      wait_frame(1);
      compare_bank("frame1", exp_word);
      send_frame(SAMPLE_GAP);
      wait_frame(2);
      compare_bank("frame2", exp_word);

      // Writes are acked and dropped
      bus_cycle(1'b1, 3, 16'h5a5a, value);
      bus_cycle(1'b1, STATUS_ADDR, 16'h00ff, value);
      held_word = exp_word;
      compare_bank("after_write", held_word);
      bus_cycle(1'b0, STATUS_ADDR, 0, value);
      check_equal("status_after_write", 2, value);

      // Frame 3 at minimum spacing while reads still see frame 2
      fork
         send_frame(TRATE);
         begin
            repeat (50) tick();
            compare_bank("during_frame3", held_word);
            bus_cycle(1'b0, STATUS_ADDR, 0, value);
            check_equal("status_during_frame3", 2, value);
         end
      join
      wait_frame(3);
      compare_bank("frame3", exp_word);

      repeat (4) tick();
      if (u_dut.u_assert.fail_cnt != 0) begin
         $display("TEST FAILED");
         $fatal(1);
      end else begin
         $display("TEST OK");
         $finish;
      end
   end

endmodule

`default_nettype wire

// ==== verilog.f ====
logic/corr_pkg.sv
logic/corr_sequencer.sv
logic/cos_sin_accum.sv
logic/corr_block.sv
logic/vis_bank.sv
logic/corr_top.sv
verif/corr_assert.sv
verif/corr_tb.sv
